// File: pdu_config.svh
`ifndef PDU_CONFIG_SVH
`define PDU_CONFIG_SVH

// flit geometry
`define FLIT_WIDTH     512
`define FLIT_BYTES     64
`define EMPTY_WIDTH    6    // in_empty counts unused bytes of the eop flit

// ring buffer
`define PDU_AWIDTH     10
`define RB_DEPTH       (1 << `PDU_AWIDTH)

// running pdu id carried in the header
`define PDUID_WIDTH    32

// largest pdu, header included
// almost_full is raised while fewer slots than this are free
`define MAX_PDU_FLITS  32

`endif

// File: pdu_gen.sv
`timescale 1ns/1ns
`include "pdu_config.svh"

module pdu_gen import pdu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    // packet stream
    input  logic                        in_sop,
    input  logic                        in_eop,
    input  logic [`FLIT_WIDTH-1:0]      in_data,
    input  logic [`EMPTY_WIDTH-1:0]     in_empty,
    input  logic                        in_valid,
    output logic                        in_ready,
    // one metadata word per packet
    input  logic                        in_meta_valid,
    input  metadata_t                   in_meta_data,
    output logic                        in_meta_ready,
    // ring space
    input  logic [`PDU_AWIDTH-1:0]      base_addr,
    input  logic                        base_addr_valid,
    input  logic                        almost_full,
    output logic                        update_valid,
    output logic [`PDU_AWIDTH-1:0]      update_size,
    // flit writes into the ring store
    rb_wr_if.gen                        wr
);

    typedef enum logic [1:0] {
        START,
        WRITE,
        WRITE_HEAD,
        WAIT
    } state_t;

    state_t                     state;

    // first pipeline stage, the interface registers are the second
    logic                       pdu_wren_r;
    logic                       pdu_sop_r;
    logic                       pdu_eop_r;
    pdu_word_u                  pdu_data_r;
    logic [`PDU_AWIDTH-1:0]     pdu_addr_r;

    logic [15:0]                pdu_size;
    logic [15:0]                pdu_flit;   // payload flits of the current pdu
    logic [15:0]                flit_bytes;
    logic [`PDUID_WIDTH-1:0]    pdu_id;
    pdu_word_u                  hdr_word;

    // byte 0 of the input goes to the top byte
    function automatic logic [`FLIT_WIDTH-1:0] byte_rev(input logic [`FLIT_WIDTH-1:0] d);
        logic [`FLIT_WIDTH-1:0] r;
        for (int i = 0; i < `FLIT_BYTES; i++) begin
            r[8*i +: 8] = d[`FLIT_WIDTH-1-8*i -: 8];
        end
        return r;
    endfunction

    assign in_ready = (state == WRITE);

    // valid bytes in the flit being accepted
    assign flit_bytes = in_eop ? 16'(`FLIT_BYTES) - {{(16-`EMPTY_WIDTH){1'b0}}, in_empty}
                               : 16'(`FLIT_BYTES);

    always_comb begin
        hdr_word                 = '0;
        hdr_word.hdr.tuple       = in_meta_data.tuple;
        hdr_word.hdr.prot        = in_meta_data.prot;
        hdr_word.hdr.pdu_id      = pdu_id;
        hdr_word.hdr.num_ruleID  = '0;
        hdr_word.hdr.pdu_size    = pdu_size;
        hdr_word.hdr.pdu_flit    = pdu_flit + 16'd1;  // header slot counts too
        hdr_word.hdr.action      = ACTION_CHECK;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= START;
            in_meta_ready <= 1'b0;
            pdu_wren_r    <= 1'b0;
            pdu_sop_r     <= 1'b0;
            pdu_eop_r     <= 1'b0;
            update_valid  <= 1'b0;
            update_size   <= '0;
            pdu_flit      <= '0;
            pdu_id        <= '0;
        end else begin
            pdu_wren_r    <= 1'b0;
            pdu_sop_r     <= 1'b0;
            pdu_eop_r     <= 1'b0;
            in_meta_ready <= 1'b0;
            update_valid  <= 1'b0;
            case (state)
                START: begin
                    pdu_flit <= '0;
                    if (in_meta_valid && !in_meta_ready && !almost_full) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (in_valid && in_ready) begin
                        pdu_wren_r     <= 1'b1;
                        pdu_data_r.raw <= byte_rev(in_data);
                        pdu_flit       <= pdu_flit + 16'd1;
                        if (in_sop) begin
                            pdu_addr_r <= base_addr + 1'b1;  // slot base is kept for the header
                            pdu_size   <= flit_bytes;
                        end else begin
                            pdu_addr_r <= pdu_addr_r + 1'b1;
                            pdu_size   <= pdu_size + flit_bytes;
                        end
                        if (in_eop) begin
                            pdu_eop_r <= 1'b1;
                            state     <= WRITE_HEAD;
                        end
                    end
                end
                WRITE_HEAD: begin
                    pdu_wren_r    <= 1'b1;
                    pdu_sop_r     <= 1'b1;
                    pdu_addr_r    <= base_addr;
                    pdu_data_r    <= hdr_word;
                    in_meta_ready <= 1'b1;     // metadata consumed with the header
                    update_valid  <= 1'b1;
                    update_size   <= pdu_flit[`PDU_AWIDTH-1:0] + 1'b1;
                    pdu_id        <= pdu_id + 1'b1;
                    state         <= WAIT;
                end
                WAIT: begin
                    pdu_flit <= '0;
                    // hold until the allocator has moved the base
                    if (in_meta_valid && !in_meta_ready && !almost_full && base_addr_valid) begin
                        state <= WRITE;
                    end
                end
                default: state <= START;
            endcase
        end
    end

    // output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            wr.en <= 1'b0;
        end else begin
            wr.en <= pdu_wren_r;
        end
    end

    always_ff @(posedge clk) begin
        wr.data.word <= pdu_data_r;
        wr.data.sop  <= pdu_sop_r;
        wr.data.eop  <= pdu_eop_r;
        wr.addr      <= pdu_addr_r;
    end

endmodule

// File: pdu_pkg.sv
`include "pdu_config.svh"

package pdu_pkg;

    // flow tuple, 96 bits
    typedef struct packed {
        logic [31:0] sip;
        logic [31:0] dip;
        logic [15:0] sport;
        logic [15:0] dport;
    } tuple_t;

    typedef struct packed {
        tuple_t      tuple;
        logic [31:0] prot;
    } metadata_t;

    // fixed header fields, the rest of the flit is zero padding
    localparam int HDR_USED_W = $bits(tuple_t) + 32 + `PDUID_WIDTH + 32 + 16 + 16 + 8;
    localparam int HDR_PAD_W  = `FLIT_WIDTH - HDR_USED_W;

    typedef struct packed {
        tuple_t                  tuple;
        logic [31:0]             prot;
        logic [`PDUID_WIDTH-1:0] pdu_id;
        logic [31:0]             num_ruleID;  // no rule matching here, always zero
        logic [15:0]             pdu_size;    // payload bytes
        logic [15:0]             pdu_flit;    // payload flits plus the header
        logic [7:0]              action;
        logic [HDR_PAD_W-1:0]    padding;
    } pdu_hdr_t;

    // one slot word, read as raw payload or as a header depending on sop
    typedef union packed {
        logic [`FLIT_WIDTH-1:0] raw;
        pdu_hdr_t               hdr;
    } pdu_word_u;

    typedef struct packed {
        pdu_word_u word;
        logic      sop;   // set on the header slot only
        logic      eop;   // set on the last payload slot
    } flit_lite_t;

    // inspection engine action written into every header
    localparam logic [7:0] ACTION_CHECK = 8'h01;

endpackage

// File: pdu_top.sv
`timescale 1ns/1ns
`include "pdu_config.svh"

module pdu_top import pdu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    // packet stream
    input  logic                        in_sop,
    input  logic                        in_eop,
    input  logic [`FLIT_WIDTH-1:0]      in_data,
    input  logic [`EMPTY_WIDTH-1:0]     in_empty,
    input  logic                        in_valid,
    output logic                        in_ready,
    // metadata
    input  logic                        in_meta_valid,
    input  metadata_t                   in_meta_data,
    output logic                        in_meta_ready,
    // host read-back
    input  logic                        rd_en,
    input  logic [`PDU_AWIDTH-1:0]      rd_addr,
    output flit_lite_t                  rd_data,
    // host frees
    input  logic                        free_valid,
    input  logic [`PDU_AWIDTH-1:0]      free_size,
    // pdu size reports and ring status
    output logic                        update_valid,
    output logic [`PDU_AWIDTH-1:0]      update_size,
    output logic                        almost_full
);

    logic [`PDU_AWIDTH-1:0] base_addr;
    logic                   base_addr_valid;

    rb_wr_if u_wr_if ();

    pdu_gen u_pdu_gen (
        .clk             (clk),
        .rst             (rst),
        .in_sop          (in_sop),
        .in_eop          (in_eop),
        .in_data         (in_data),
        .in_empty        (in_empty),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_meta_valid   (in_meta_valid),
        .in_meta_data    (in_meta_data),
        .in_meta_ready   (in_meta_ready),
        .base_addr       (base_addr),
        .base_addr_valid (base_addr_valid),
        .almost_full     (almost_full),
        .update_valid    (update_valid),
        .update_size     (update_size),
        .wr              (u_wr_if.gen)
    );

    rb_alloc u_rb_alloc (
        .clk             (clk),
        .rst             (rst),
        .update_valid    (update_valid),
        .update_size     (update_size),
        .free_valid      (free_valid),
        .free_size       (free_size),
        .base_addr       (base_addr),
        .base_addr_valid (base_addr_valid),
        .almost_full     (almost_full)
    );

    rb_mem u_rb_mem (
        .clk             (clk),
        .wr              (u_wr_if.mem),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data)
    );

endmodule

// File: pdu_top_props.sv
`timescale 1ns/1ns

// handshake rules at the pdu top level
module pdu_top_props (
    input logic clk,
    input logic rst,
    input logic in_ready,
    input logic in_meta_ready,
    input logic update_valid,
    input logic almost_full
);

    property update_is_pulse;
        @(posedge clk) disable iff (rst)
        update_valid |=> !update_valid;
    endproperty

    // metadata is consumed together with the size report
    property meta_ready_with_update;
        @(posedge clk) disable iff (rst)
        in_meta_ready == update_valid;
    endproperty

    property no_start_when_full;
        @(posedge clk) disable iff (rst)
        $rose(in_ready) |-> !$past(almost_full);
    endproperty

    property quiet_after_reset;
        @(posedge clk) disable iff (rst)
        $fell(rst) |-> (!in_ready && !in_meta_ready && !update_valid && !almost_full);
    endproperty

    a_update_pulse: assert property (update_is_pulse)
        else $error("update_valid stayed high for more than one cycle");
    a_meta_update: assert property (meta_ready_with_update)
        else $error("in_meta_ready and update_valid did not pulse together");
    a_no_start_full: assert property (no_start_when_full)
        else $error("in_ready rose while almost_full was high");
    a_reset_state: assert property (quiet_after_reset)
        else $error("outputs not idle right after reset");

endmodule

bind pdu_top pdu_top_props u_pdu_top_props (
    .clk             (clk),
    .rst             (rst),
    .in_ready        (in_ready),
    .in_meta_ready   (in_meta_ready),
    .update_valid    (update_valid),
    .almost_full     (almost_full)
);

// File: rb_alloc.sv
`timescale 1ns/1ns
`include "pdu_config.svh"

module rb_alloc (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        update_valid,
    input  logic [`PDU_AWIDTH-1:0]      update_size,
    input  logic                        free_valid,
    input  logic [`PDU_AWIDTH-1:0]      free_size,
    output logic [`PDU_AWIDTH-1:0]      base_addr,
    output logic                        base_addr_valid,
    output logic                        almost_full
);

    localparam logic [`PDU_AWIDTH:0] DEPTH  = (`PDU_AWIDTH+1)'(`RB_DEPTH);
    localparam logic [`PDU_AWIDTH:0] MARGIN = (`PDU_AWIDTH+1)'(`MAX_PDU_FLITS);

    logic [`PDU_AWIDTH:0]   used_cnt;   // one bit wider, the ring can be full
    logic [`PDU_AWIDTH:0]   used_inc;
    logic [`PDU_AWIDTH:0]   used_dec;
    logic [`PDU_AWIDTH:0]   free_cnt;

    assign used_inc = update_valid ? {1'b0, update_size} : '0;
    assign used_dec = free_valid ? {1'b0, free_size} : '0;
    assign free_cnt = DEPTH - used_cnt;

    // head pointer, wraps modulo the ring depth
    always_ff @(posedge clk) begin
        if (rst) begin
            base_addr       <= '0;
            base_addr_valid <= 1'b1;
        end else begin
            if (update_valid) begin
                base_addr <= base_addr + update_size;
            end
            base_addr_valid <= !update_valid;  // low for one cycle while the head moves
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            used_cnt    <= '0;
            almost_full <= 1'b0;
        end else begin
            used_cnt    <= used_cnt + used_inc - used_dec;
            almost_full <= free_cnt < MARGIN;  // lags used_cnt by a cycle
        end
    end

endmodule

// File: rb_mem.sv
`timescale 1ns/1ns
`include "pdu_config.svh"

// ring buffer slots, one write port and one host read port
module rb_mem import pdu_pkg::*; (
    input  logic                        clk,
    rb_wr_if.mem                        wr,
    input  logic                        rd_en,
    input  logic [`PDU_AWIDTH-1:0]      rd_addr,
    output flit_lite_t                  rd_data
);

    flit_lite_t mem [`RB_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // same-slot read and write return the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: rb_wr_if.sv
`timescale 1ns/1ns
`include "pdu_config.svh"

// flit write path from the pdu writer into the ring store
// one write per cycle with en high, no back-pressure
interface rb_wr_if import pdu_pkg::*; ();

    flit_lite_t              data;
    logic [`PDU_AWIDTH-1:0]  addr;
    logic                    en;

    modport gen (
        output data,
        output addr,
        output en
    );

    modport mem (
        input data,
        input addr,
        input en
    );

endinterface

// File: run.sh
#!/bin/sh
# build with Verilator, run, and judge the result from the log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_pdu_top \
    -o Vtb_pdu_top > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_pdu_top > sim.log 2>&1
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "simulation did not complete"; exit 1; }
exit 0

// File: tb_pdu_top.sv
`timescale 1ns/1ns
`include "pdu_config.svh"

module tb_pdu_top import pdu_pkg::*; ();

    localparam int SEED       = 22947;
    localparam int MAX_FLITS  = 8;
    localparam int BP_HOLD    = 40;   // cycles a pdu waits on a full ring before the free
    localparam int WRAP_EXTRA = 4;
    // worst pdu: flits, handshake gap, settle, two cycles per slot read
    localparam int PDU_CYCLES = MAX_FLITS + 10 + 2 * (MAX_FLITS + 1);
    // fill and wrap each need at most RB_DEPTH/2 pdus of two or more slots
    localparam int MAX_PDUS   = `RB_DEPTH + 1 + WRAP_EXTRA;
    localparam int TIMEOUT_CYCLES = MAX_PDUS * PDU_CYCLES + BP_HOLD + 200;

    logic                       clk;
    logic                       rst;
    logic                       in_sop;
    logic                       in_eop;
    logic [`FLIT_WIDTH-1:0]     in_data;
    logic [`EMPTY_WIDTH-1:0]    in_empty;
    logic                       in_valid;
    logic                       in_ready;
    logic                       in_meta_valid;
    metadata_t                  in_meta_data;
    logic                       in_meta_ready;
    logic                       rd_en;
    logic [`PDU_AWIDTH-1:0]     rd_addr;
    flit_lite_t                 rd_data;
    logic                       free_valid;
    logic [`PDU_AWIDTH-1:0]     free_size;
    logic                       update_valid;
    logic [`PDU_AWIDTH-1:0]     update_size;
    logic                       almost_full;

    logic [31:0]                rng_state;
    logic [`FLIT_WIDTH-1:0]     pkt_data [MAX_FLITS];
    logic [`PDU_AWIDTH-1:0]     head;     // reference ring head
    int                         used;
    bit                         wrapped;
    int                         last_slots;
    int                         pdu_count;
    int                         first_acc_cyc;
    int                         free_cyc;
    int                         extra;
    int                         checks;
    int                         errors;
    int                         c0;
    int                         e0;
    int                         n_tests;
    int                         cycle = 0;
    int                         upd_seen = 0;

    pdu_top u_pdu_top (
        .clk           (clk),
        .rst           (rst),
        .in_sop        (in_sop),
        .in_eop        (in_eop),
        .in_data       (in_data),
        .in_empty      (in_empty),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_meta_valid (in_meta_valid),
        .in_meta_data  (in_meta_data),
        .in_meta_ready (in_meta_ready),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .free_valid    (free_valid),
        .free_size     (free_size),
        .update_valid  (update_valid),
        .update_size   (update_size),
        .almost_full   (almost_full)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst && update_valid) begin
            upd_seen <= upd_seen + 1;
        end
        if (cycle == TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, the DUT stopped making progress", cycle);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] rand_word();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // packet byte 0 ends up in the top byte of the slot
    function automatic logic [`FLIT_WIDTH-1:0] byte_reversed(input logic [`FLIT_WIDTH-1:0] d);
        logic [`FLIT_WIDTH-1:0] r;
        for (int j = 0; j < `FLIT_BYTES; j++) begin
            r[8*(`FLIT_BYTES-1-j) +: 8] = d[8*j +: 8];
        end
        return r;
    endfunction

    task automatic check_eq(input string what, input logic [511:0] got, input logic [511:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-12s %0d checks, %0d errors", name, checks - c0, errors - e0);
        n_tests++;
        c0 = checks;
        e0 = errors;
    endtask

    task automatic present_flit(input int i, input int n, input logic [`EMPTY_WIDTH-1:0] empty);
        in_data  <= pkt_data[i];
        in_sop   <= (i == 0);
        in_eop   <= (i == n - 1);
        in_empty <= (i == n - 1) ? empty : '0;
        in_valid <= 1'b1;
    endtask

    // called on a rising edge, returns on a rising edge
    task automatic read_slot(input logic [`PDU_AWIDTH-1:0] addr, output flit_lite_t slot);
        rd_en   <= 1'b1;
        rd_addr <= addr;
        @(posedge clk);
        rd_en   <= 1'b0;
        @(posedge clk);
        slot = rd_data;
    endtask

    task automatic free_slots(input int cnt);
        free_valid <= 1'b1;
        free_size  <= cnt[`PDU_AWIDTH-1:0];
        used = used - cnt;
        @(posedge clk);
        free_valid <= 1'b0;
    endtask

    task automatic run_pdu();
        int                      n;
        int                      idx;
        logic [`EMPTY_WIDTH-1:0] empty;
        logic [15:0]             exp_size;
        metadata_t               meta;
        logic [`PDU_AWIDTH-1:0]  base;
        flit_lite_t              slot;

        n = 1 + int'(rand_word() % MAX_FLITS);
        empty = `EMPTY_WIDTH'(rand_word());
        meta.tuple.sip   = rand_word();
        meta.tuple.dip   = rand_word();
        meta.tuple.sport = 16'(rand_word());
        meta.tuple.dport = 16'(rand_word());
        meta.prot        = rand_word();
        for (int i = 0; i < n; i++) begin
            for (int w = 0; w < `FLIT_WIDTH / 32; w++) begin
                pkt_data[i][32*w +: 32] = rand_word();
            end
        end
        exp_size = 16'(`FLIT_BYTES * (n - 1) + `FLIT_BYTES - int'(empty));

        in_meta_data  <= meta;
        in_meta_valid <= 1'b1;
        idx = 0;
        present_flit(0, n, empty);
        while (idx < n) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                if (idx == 0) begin
                    first_acc_cyc = cycle;
                end
                idx++;
                if (idx < n) begin
                    present_flit(idx, n, empty);
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
        while (!in_meta_ready) begin
            @(posedge clk);
        end
        in_meta_valid <= 1'b0;
        check_eq("update_valid with meta ready", update_valid, 1'b1);
        check_eq("update_size", update_size, n + 1);

        base = head;
        head = head + `PDU_AWIDTH'(n + 1);
        if (head < base) begin
            wrapped = 1'b1;
        end
        used = used + n + 1;
        last_slots = n + 1;
        repeat (2) @(posedge clk);   // header lands two edges after meta ready

        read_slot(base, slot);
        check_eq("header sop", slot.sop, 1'b1);
        check_eq("header eop", slot.eop, 1'b0);
        check_eq("header tuple", slot.word.hdr.tuple, meta.tuple);
        check_eq("header prot", slot.word.hdr.prot, meta.prot);
        check_eq("header pdu_id", slot.word.hdr.pdu_id, pdu_count);
        check_eq("header pdu_size", slot.word.hdr.pdu_size, exp_size);
        check_eq("header pdu_flit", slot.word.hdr.pdu_flit, n + 1);
        check_eq("header action", slot.word.hdr.action, ACTION_CHECK);
        for (int i = 0; i < n; i++) begin
            read_slot(base + `PDU_AWIDTH'(i + 1), slot);
            check_eq($sformatf("pdu %0d flit %0d data", pdu_count, i), slot.word.raw,
                     byte_reversed(pkt_data[i]));
            check_eq($sformatf("pdu %0d flit %0d sop", pdu_count, i), slot.sop, 1'b0);
            check_eq($sformatf("pdu %0d flit %0d eop", pdu_count, i), slot.eop, i == n - 1);
        end
        check_eq("almost_full level", almost_full, (`RB_DEPTH - used) < `MAX_PDU_FLITS);
        pdu_count++;
    endtask

    initial begin
        rng_state     = SEED;
        head          = '0;
        used          = 0;
        wrapped       = 1'b0;
        pdu_count     = 0;
        checks        = 0;
        errors        = 0;
        c0            = 0;
        e0            = 0;
        n_tests       = 0;
        rst           = 1'b1;
        in_sop        = 1'b0;
        in_eop        = 1'b0;
        in_data       = '0;
        in_empty      = '0;
        in_valid      = 1'b0;
        in_meta_valid = 1'b0;
        in_meta_data  = '0;
        rd_en         = 1'b0;
        rd_addr       = '0;
        free_valid    = 1'b0;
        free_size     = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_eq("in_ready after reset", in_ready, 1'b0);
        check_eq("in_meta_ready after reset", in_meta_ready, 1'b0);
        check_eq("update_valid after reset", update_valid, 1'b0);
        check_eq("almost_full after reset", almost_full, 1'b0);
        report_test("reset");

        // no frees, runs until the ring reports almost full
        while ((`RB_DEPTH - used) >= `MAX_PDU_FLITS) begin
            run_pdu();
        end
        report_test("fill");

        fork
            run_pdu();
            begin
                repeat (BP_HOLD) @(posedge clk);
                free_cyc = cycle;
                free_slots(used);
            end
        join
        check_eq("first flit accepted after the free", first_acc_cyc > free_cyc, 1'b1);
        report_test("backpressure");

        extra = 0;
        while (!wrapped || extra < WRAP_EXTRA) begin
            if (wrapped) begin
                extra++;
            end
            run_pdu();
            free_slots(last_slots);
        end
        check_eq("update_valid pulses per pdu", upd_seen, pdu_count);
        report_test("wrap");

        $display("done: %0d tests, %0d pdus, %0d checks, %0d errors",
                 n_tests, pdu_count, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
pdu_pkg.sv
rb_wr_if.sv
pdu_gen.sv
rb_alloc.sv
rb_mem.sv
pdu_top.sv
pdu_top_props.sv
tb_pdu_top.sv
